// File: rtl/cache_pkg.sv
/*
  cache package
  address-field constants, data types and controller states shared by
  the direct-mapped write-back cache
*/
`default_nettype none

package cache_pkg;

  // |tag|line|col|00| split of a processor byte address
  localparam int ZERO_BITS = 2;
  localparam int COLUMN_BITS = 3;
  localparam int WORDS_PER_LINE = 8;
  localparam int BEATS_PER_LINE = 4;

  typedef logic [31:0] word_t;
  typedef logic [3:0] byte_en_t;
  typedef logic [63:0] beat_t;
  typedef logic [COLUMN_BITS-1:0] column_ix_t;
  typedef logic [1:0] beat_ix_t;

  // one processor request, write_enable of zero is a read
  typedef struct packed {
    word_t address;
    word_t data;
    byte_en_t write_enable;
  } cache_req_t;

  // tag field sized for a zero-bit line index, unused upper bits stay zero
  typedef struct packed {
    logic dirty;
    logic valid;
    logic [31-ZERO_BITS:0] tag;
  } tag_entry_t;

  // one beat written into the line being filled
  typedef struct packed {
    logic strobe;
    beat_ix_t index;
    beat_t data;
  } fill_beat_t;

  typedef enum logic [2:0] {
    IDLE,
    EVICT_BEAT,
    READ_CMD,
    READ_WAIT,
    FILL_BEAT,
    TAG_UPDATE,
    FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: rtl/cache_tag_store.sv
/*
  cache tag store
  one tag entry per line with valid and dirty flags, hit detection and
  the burst RAM address of the line currently held at the request index
*/
`timescale 1ns/10ps
`default_nettype none

module cache_tag_store #(
  parameter int LINE_IX_BITS = 8,
  parameter int RAM_DEPTH_BITS = 10
) (
  input logic clk,
  input logic rst,
  input cache_pkg::cache_req_t req,
  input logic tag_write,
  output logic hit,
  output logic victim_dirty,
  output logic [RAM_DEPTH_BITS-1:0] victim_addr
);
  import cache_pkg::*;

  localparam int LINES = 2 ** LINE_IX_BITS;
  localparam int TAG_SHIFT = ZERO_BITS + COLUMN_BITS + LINE_IX_BITS;
  localparam int TAG_FIELD_BITS = $bits(tag_entry_t) - 2;

  logic [LINE_IX_BITS-1:0] line_ix;
  logic [TAG_FIELD_BITS-1:0] addr_tag;
  tag_entry_t entry_mem [LINES];
  logic [LINES-1:0] valid_q;
  tag_entry_t entry;

  assign line_ix = req.address[ZERO_BITS + COLUMN_BITS +: LINE_IX_BITS];
  // upper address bits, zero-extended into the tag field
  assign addr_tag = TAG_FIELD_BITS'(req.address >> TAG_SHIFT);

  // valid comes from the resettable flops, the rest from the array
  always_comb begin
    entry = entry_mem[line_ix];
    entry.valid = valid_q[line_ix];
  end

  assign hit = entry.valid && (entry.tag == addr_tag);
  assign victim_dirty = entry.valid && entry.dirty;
  // line number times four, in 8-byte RAM words
  assign victim_addr = RAM_DEPTH_BITS'({entry.tag, line_ix, 2'b00});

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (tag_write) begin
      valid_q[line_ix] <= 1'b1;
    end
  end

  // refill stores a clean entry, a write hit marks the line dirty
  always_ff @(posedge clk) begin
    if (tag_write) begin
      entry_mem[line_ix] <= '{dirty: 1'b0, valid: 1'b1, tag: addr_tag};
    end else if (hit && req.write_enable != '0) begin
      entry_mem[line_ix] <= '{dirty: 1'b1, valid: 1'b1, tag: addr_tag};
    end
  end

endmodule

`default_nettype wire

// File: rtl/cache_data_store.sv
/*
  cache data store
  eight byte-writable word columns indexed by line, with processor access,
  refill beat writes and victim beat reads for write-back
*/
`timescale 1ns/10ps
`default_nettype none

module cache_data_store #(
  parameter int LINE_IX_BITS = 8
) (
  input logic clk,
  input cache_pkg::cache_req_t req,
  input logic hit,
  input cache_pkg::fill_beat_t fill,
  input cache_pkg::beat_ix_t victim_ix,
  output cache_pkg::word_t data_out,
  output logic data_out_ready,
  output cache_pkg::beat_t victim_beat
);
  import cache_pkg::*;

  localparam int LINES = 2 ** LINE_IX_BITS;
  localparam int BYTES_PER_WORD = $bits(byte_en_t);

  logic [LINE_IX_BITS-1:0] line_ix;
  column_ix_t col_ix;
  logic wr_hit;
  word_t col_rd [WORDS_PER_LINE];

  assign line_ix = req.address[ZERO_BITS + COLUMN_BITS +: LINE_IX_BITS];
  assign col_ix = req.address[ZERO_BITS +: COLUMN_BITS];
  assign wr_hit = hit && (req.write_enable != '0);

  for (genvar c = 0; c < WORDS_PER_LINE; c++) begin : g_col
    // a beat covers two columns, the even one in the low half
    localparam beat_ix_t BEAT = beat_ix_t'(c / 2);
    localparam int HALF = c % 2;

    word_t col_mem [LINES];

    always_ff @(posedge clk) begin
      if (fill.strobe && fill.index == BEAT) begin
        col_mem[line_ix] <= fill.data[32*HALF +: 32];
      end else if (wr_hit && col_ix == column_ix_t'(c)) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
          if (req.write_enable[b]) begin
            col_mem[line_ix][8*b +: 8] <= req.data[8*b +: 8];
          end
        end
      end
    end

    assign col_rd[c] = col_mem[line_ix];
  end

  assign data_out = col_rd[col_ix];
  // only reads report ready, writes finish when busy drops
  assign data_out_ready = hit && (req.write_enable == '0);

  assign victim_beat = {col_rd[column_ix_t'({victim_ix, 1'b1})],
                        col_rd[column_ix_t'({victim_ix, 1'b0})]};

endmodule

`default_nettype wire

// File: rtl/cache_burst_ctrl.sv
/*
  cache burst controller
  on a miss writes back a dirty victim line, then refills the requested
  line from the burst RAM and validates its tag
*/
`timescale 1ns/10ps
`default_nettype none

module cache_burst_ctrl #(
  parameter int RAM_DEPTH_BITS = 10
) (
  input logic clk,
  input logic rst,
  input cache_pkg::cache_req_t req,
  input logic hit,
  input logic victim_dirty,
  input logic [RAM_DEPTH_BITS-1:0] victim_addr,
  input cache_pkg::beat_t victim_beat,
  output cache_pkg::beat_ix_t victim_ix,
  output cache_pkg::fill_beat_t fill,
  output logic tag_write,
  output logic br_cmd,
  output logic br_cmd_en,
  output logic [RAM_DEPTH_BITS-1:0] br_addr,
  output cache_pkg::beat_t br_wr_data,
  input cache_pkg::beat_t br_rd_data,
  input logic br_rd_data_ready
);
  import cache_pkg::*;

  localparam beat_ix_t LAST_BEAT = beat_ix_t'(BEATS_PER_LINE - 1);

  ctrl_state_t state_q;
  beat_ix_t beat_q;
  logic [RAM_DEPTH_BITS-1:0] line_addr;

  // line number of the request times four, in 8-byte RAM words
  assign line_addr = RAM_DEPTH_BITS'({req.address[31:ZERO_BITS + COLUMN_BITS], 2'b00});

  // the beat counter is zero in idle, so eviction starts at beat 0
  assign victim_ix = beat_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      beat_q <= '0;
      br_cmd <= 1'b0;
      br_cmd_en <= 1'b0;
      tag_write <= 1'b0;
      fill.strobe <= 1'b0;
    end else begin
      // single-cycle strobes
      br_cmd_en <= 1'b0;
      tag_write <= 1'b0;
      fill.strobe <= 1'b0;

      case (state_q)
        IDLE: begin
          if (!hit) begin
            br_cmd_en <= 1'b1;
            if (victim_dirty) begin
              // write command goes out together with beat 0
              br_cmd <= 1'b1;
              br_addr <= victim_addr;
              br_wr_data <= victim_beat;
              beat_q <= beat_q + beat_ix_t'(1);
              state_q <= EVICT_BEAT;
            end else begin
              br_cmd <= 1'b0;
              br_addr <= line_addr;
              state_q <= READ_WAIT;
            end
          end
        end

        EVICT_BEAT: begin
          br_wr_data <= victim_beat;
          // counter wraps back to zero for the fill
          beat_q <= beat_q + beat_ix_t'(1);
          if (beat_q == LAST_BEAT) begin
            state_q <= READ_CMD;
          end
        end

        READ_CMD: begin
          br_cmd <= 1'b0;
          br_cmd_en <= 1'b1;
          br_addr <= line_addr;
          state_q <= READ_WAIT;
        end

        READ_WAIT: begin
          // first beat may take any number of cycles
          if (br_rd_data_ready) begin
            fill <= '{strobe: 1'b1, index: beat_q, data: br_rd_data};
            beat_q <= beat_q + beat_ix_t'(1);
            state_q <= FILL_BEAT;
          end
        end

        FILL_BEAT: begin
          // remaining beats arrive back to back
          fill <= '{strobe: 1'b1, index: beat_q, data: br_rd_data};
          beat_q <= beat_q + beat_ix_t'(1);
          if (beat_q == LAST_BEAT) begin
            state_q <= TAG_UPDATE;
          end
        end

        TAG_UPDATE: begin
          tag_write <= 1'b1;
          state_q <= FINISH;
        end

        FINISH: begin
          state_q <= IDLE;
        end

        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/cache_top.sv
/*
  direct-mapped write-back data cache
  32-bit processor port in front of a 64-bit burst RAM
*/
`timescale 1ns/10ps
`default_nettype none

module cache_top #(
  parameter int LINE_IX_BITS = 8,
  parameter int RAM_DEPTH_BITS = 10
) (
  input logic clk,
  input logic rst,
  input cache_pkg::cache_req_t req,
  output cache_pkg::word_t data_out,
  output logic data_out_ready,
  output logic busy,
  output logic br_cmd,
  output logic br_cmd_en,
  output logic [RAM_DEPTH_BITS-1:0] br_addr,
  output cache_pkg::beat_t br_wr_data,
  input cache_pkg::beat_t br_rd_data,
  input logic br_rd_data_ready
);
  import cache_pkg::*;

  logic hit;
  logic victim_dirty;
  logic [RAM_DEPTH_BITS-1:0] victim_addr;
  logic tag_write;
  fill_beat_t fill;
  beat_ix_t victim_ix;
  beat_t victim_beat;

  // processor holds req stable while the line is missing
  assign busy = !hit;

  cache_tag_store #(
    .LINE_IX_BITS(LINE_IX_BITS),
    .RAM_DEPTH_BITS(RAM_DEPTH_BITS)
  ) u_tag_store (
    .clk(clk),
    .rst(rst),
    .req(req),
    .tag_write(tag_write),
    .hit(hit),
    .victim_dirty(victim_dirty),
    .victim_addr(victim_addr)
  );

  cache_data_store #(
    .LINE_IX_BITS(LINE_IX_BITS)
  ) u_data_store (
    .clk(clk),
    .req(req),
    .hit(hit),
    .fill(fill),
    .victim_ix(victim_ix),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .victim_beat(victim_beat)
  );

  cache_burst_ctrl #(
    .RAM_DEPTH_BITS(RAM_DEPTH_BITS)
  ) u_burst_ctrl (
    .clk(clk),
    .rst(rst),
    .req(req),
    .hit(hit),
    .victim_dirty(victim_dirty),
    .victim_addr(victim_addr),
    .victim_beat(victim_beat),
    .victim_ix(victim_ix),
    .fill(fill),
    .tag_write(tag_write),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .br_rd_data(br_rd_data),
    .br_rd_data_ready(br_rd_data_ready)
  );

endmodule

`default_nettype wire

// File: testbench/burst_ram_model.sv
/*
  burst RAM model
  64-bit word memory that answers write commands with four incoming beats
  and read commands with four outgoing beats after a fixed delay
*/
`timescale 1ns/10ps
`default_nettype none

module burst_ram_model #(
  parameter int DEPTH_BITS = 8
) (
  input logic clk,
  input logic rst,
  input logic br_cmd,
  input logic br_cmd_en,
  input logic [DEPTH_BITS-1:0] br_addr,
  input cache_pkg::beat_t br_wr_data,
  output cache_pkg::beat_t br_rd_data,
  output logic br_rd_data_ready
);
  import cache_pkg::*;

  localparam int READ_DELAY = 3;

  beat_t mem [2 ** DEPTH_BITS];
  logic [DEPTH_BITS-1:0] wr_addr;
  logic [DEPTH_BITS-1:0] rd_addr;
  int wr_left;
  int rd_delay;
  int rd_left;

  always @(posedge clk) begin
    if (rst) begin
      // each 32-bit word starts as its byte address xor a fixed pattern
      for (int i = 0; i < 2 ** DEPTH_BITS; i++) begin
        mem[i] <= {word_t'(8 * i + 4) ^ 32'h5a5a_0000, word_t'(8 * i) ^ 32'h5a5a_0000};
      end
      wr_left <= 0;
      rd_delay <= 0;
      rd_left <= 0;
      br_rd_data <= '0;
      br_rd_data_ready <= 1'b0;
    end else begin
      // beat 0 of a write arrives together with the command
      if (br_cmd_en && br_cmd) begin
        mem[br_addr] <= br_wr_data;
        wr_addr <= br_addr + DEPTH_BITS'(1);
        wr_left <= 3;
      end else if (wr_left > 0) begin
        mem[wr_addr] <= br_wr_data;
        wr_addr <= wr_addr + DEPTH_BITS'(1);
        wr_left <= wr_left - 1;
      end

      br_rd_data_ready <= 1'b0;
      if (br_cmd_en && !br_cmd) begin
        rd_addr <= br_addr;
        rd_delay <= READ_DELAY;
      end else if (rd_delay > 0) begin
        rd_delay <= rd_delay - 1;
        if (rd_delay == 1) begin
          br_rd_data_ready <= 1'b1;
          br_rd_data <= mem[rd_addr];
          rd_addr <= rd_addr + DEPTH_BITS'(1);
          rd_left <= 3;
        end
      end else if (rd_left > 0) begin
        // remaining beats back to back
        br_rd_data_ready <= 1'b1;
        br_rd_data <= mem[rd_addr];
        rd_addr <= rd_addr + DEPTH_BITS'(1);
        rd_left <= rd_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

// File: testbench/cache_tb.sv
/*
  cache testbench
  directed and random processor traffic checked against a reference memory,
  with a burst RAM model behind the cache
*/
`timescale 1ns/10ps
`default_nettype none

module cache_tb;
  import cache_pkg::*;

  localparam int LINE_IX_BITS = 4;
  localparam int RAM_DEPTH_BITS = 8;
  localparam int MODEL_WORDS = 512;
  localparam int TIMEOUT_CYCLES = 200;

  logic clk = 1'b0;
  logic rst;
  cache_req_t req;
  word_t data_out;
  logic data_out_ready;
  logic busy;
  logic br_cmd;
  logic br_cmd_en;
  logic [RAM_DEPTH_BITS-1:0] br_addr;
  beat_t br_wr_data;
  beat_t br_rd_data;
  logic br_rd_data_ready;

  word_t model [MODEL_WORDS];
  int rd_cmd_count = 0;
  int wr_cmd_count = 0;
  logic [RAM_DEPTH_BITS-1:0] rd_cmd_addr;
  logic [RAM_DEPTH_BITS-1:0] wr_cmd_addr;
  beat_t wr_beats [$];
  int wr_beats_left = 0;

  cache_top #(
    .LINE_IX_BITS(LINE_IX_BITS),
    .RAM_DEPTH_BITS(RAM_DEPTH_BITS)
  ) dut (
    .clk(clk),
    .rst(rst),
    .req(req),
    .data_out(data_out),
    .data_out_ready(data_out_ready),
    .busy(busy),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .br_rd_data(br_rd_data),
    .br_rd_data_ready(br_rd_data_ready)
  );

  burst_ram_model #(
    .DEPTH_BITS(RAM_DEPTH_BITS)
  ) u_ram (
    .clk(clk),
    .rst(rst),
    .br_cmd(br_cmd),
    .br_cmd_en(br_cmd_en),
    .br_addr(br_addr),
    .br_wr_data(br_wr_data),
    .br_rd_data(br_rd_data),
    .br_rd_data_ready(br_rd_data_ready)
  );

  always #5 clk = ~clk;

  // RAM bus monitor sampled on the falling edge
  always @(negedge clk) begin
    if (wr_beats_left > 0) begin
      wr_beats.push_back(br_wr_data);
      wr_beats_left = wr_beats_left - 1;
    end
    if (br_cmd_en && br_cmd) begin
      wr_cmd_count = wr_cmd_count + 1;
      wr_cmd_addr = br_addr;
      wr_beats.push_back(br_wr_data);
      wr_beats_left = 3;
    end else if (br_cmd_en) begin
      rd_cmd_count = rd_cmd_count + 1;
      rd_cmd_addr = br_addr;
    end
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_beat(input string name, input beat_t expected, input beat_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
    end
  endtask

  // one request held until the cache completes it
  task automatic access(input word_t addr, input word_t data, input byte_en_t we,
                        output word_t rdata);
    int cycles;
    cycles = 0;
    req = '{address: addr, data: data, write_enable: we};
    @(negedge clk);
    while ((we == '0) ? !data_out_ready : busy) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
        report_failure($sformatf("timeout: request to address %h never completed", addr));
      end
      @(negedge clk);
    end
    rdata = data_out;
    @(posedge clk);
    #1;
  endtask

  task automatic read_check(input string name, input word_t addr);
    word_t rdata;
    access(addr, '0, '0, rdata);
    check_word(name, model[addr[10:2]], rdata);
  endtask

  task automatic write_update(input word_t addr, input word_t data, input byte_en_t we);
    word_t rdata;
    access(addr, data, we, rdata);
    for (int b = 0; b < 4; b++) begin
      if (we[b]) begin
        model[addr[10:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  initial begin
    int unsigned seed_draw;
    word_t addr;
    int rd_before;
    int wr_before;
    int beat_base;
    int line_word;

    rst = 1'b1;
    req = '0;
    seed_draw = $urandom(32'h9e5b);
    for (int i = 0; i < MODEL_WORDS; i++) begin
      model[i] = word_t'(4 * i) ^ 32'h5a5a_0000;
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    // idle after reset with every line invalid
    @(negedge clk);
    check_flag("reset cmd_en", 1'b0, br_cmd_en);
    check_flag("reset busy", 1'b1, busy);
    @(posedge clk);
    #1;
    read_check("first read", 32'h0);

    // a clean read miss gives one read command at line number times four
    addr = 32'h0000_0124;
    rd_before = rd_cmd_count;
    wr_before = wr_cmd_count;
    read_check("read miss data", addr);
    check_word("read miss commands", 32'd1, word_t'(rd_cmd_count - rd_before));
    check_word("read miss write-backs", 32'd0, word_t'(wr_cmd_count - wr_before));
    check_word("read miss address", (addr >> 5) * 4, word_t'(rd_cmd_addr));

    // write hit with a random mask and a read back
    write_update(addr + 32'h4, $urandom, byte_en_t'($urandom_range(1, 15)));
    read_check("write hit merge", addr + 32'h4);

    // dirty line evicted by a conflicting read
    addr = 32'h0000_0240;
    write_update(addr + 32'h8, $urandom, 4'hf);
    wr_before = wr_cmd_count;
    beat_base = wr_beats.size();
    read_check("conflict read", addr + 32'h200);
    check_word("eviction commands", 32'd1, word_t'(wr_cmd_count - wr_before));
    check_word("eviction address", (addr >> 5) * 4, word_t'(wr_cmd_addr));
    line_word = int'(addr[10:2]);
    for (int k = 0; k < 4; k++) begin
      check_beat($sformatf("eviction beat %0d", k),
                 {model[line_word + 2 * k + 1], model[line_word + 2 * k]},
                 wr_beats[beat_base + k]);
    end

    // random traffic over the 2 KB the RAM covers
    for (int n = 0; n < 2000; n++) begin
      addr = word_t'($urandom) & 32'h0000_07ff;
      if ($urandom_range(0, 9) < 4) begin
        write_update(addr, $urandom, byte_en_t'($urandom_range(1, 15)));
      end else begin
        read_check("random read", addr);
      end
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
rtl/cache_pkg.sv
rtl/cache_tag_store.sv
rtl/cache_data_store.sv
rtl/cache_burst_ctrl.sv
rtl/cache_top.sv
testbench/burst_ram_model.sv
testbench/cache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module cache_tb -f compile.f -Mdir obj_dir -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ok"
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
